//--- flist.f
source/dap_pkg.sv
source/ahb_slave_port.sv
source/dap_reg_file.sv
source/dap_sequencer.sv
source/dap_delay_worker.sv
source/dap_out_fifo.sv
source/dap_controller.sv
verification/tb_dap_controller.sv

//--- Makefile
SRCS := $(wildcard source/*.sv verification/*.sv)

.PHONY: run clean

obj_dir/Vtb_dap_controller: $(SRCS) flist.f
	verilator --binary --timing --top-module tb_dap_controller -f flist.f

run: obj_dir/Vtb_dap_controller
	./obj_dir/Vtb_dap_controller | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- verification/tb_dap_controller.sv
module tb_dap_controller
    import dap_pkg::*;
;

    localparam int num_rows = 3;

    logic                  hclk;
    logic                  hresetn;
    logic                  hsels;
    logic [addr_width-1:0] haddrs;
    logic [1:0]            htranss;
    logic [2:0]            hsizes;
    logic                  hwrites;
    logic                  hreadys;
    logic [31:0]           hwdatas;
    logic                  hreadyouts;
    logic                  hresps;
    logic [31:0]           hrdatas;
    logic                  intr;
    logic                  dap_in_tvalid;
    logic                  dap_in_tready;
    logic [7:0]            dap_in_tdata;
    logic                  dap_out_tvalid;
    logic [7:0]            dap_out_tdata;

    // Command table, bytes right-aligned with the first byte highest
    string       row_name     [num_rows];
    logic [63:0] row_in       [num_rows];
    int          row_in_len   [num_rows];
    logic [63:0] row_out      [num_rows];
    int          row_out_len  [num_rows];
    logic        row_mcu      [num_rows];
    logic [7:0]  row_resp     [num_rows];  // Byte the MCU answers with
    int          row_total_us [num_rows];
    int          row_last_us  [num_rows];  // Delay of the final command

    logic [7:0]  out_q [$];
    int          first_out_cycle;
    int          cycle;
    int          timeout_limit;
    int          checks;
    int          errors;
    int          tests;

    dap_controller dut (.*);

    always #2 hclk = ~hclk;

    // Output monitor, no back-pressure on this stream
    always @(negedge hclk) begin
        if (dap_out_tvalid) begin
            if (out_q.size() == 0)
                first_out_cycle = cycle;
            out_q.push_back(dap_out_tdata);
        end
    end

    always @(posedge hclk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %b expected %b", $time, what, act, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errors - errs_before);
    endtask

    // ------------------------------------------------------------
    // Bus and stream drivers
    // ------------------------------------------------------------
    task automatic ahb_write(input logic [addr_width-1:0] a, input logic [2:0] size,
                             input logic [31:0] data);
        @(posedge hclk);                                // Address phase
        hsels   <= 1'b1;
        htranss <= 2'b10;
        haddrs  <= a;
        hsizes  <= size;
        hwrites <= 1'b1;
        @(posedge hclk);                                // Data phase
        hsels   <= 1'b0;
        htranss <= 2'b00;
        hwrites <= 1'b0;
        hwdatas <= data;
        @(posedge hclk);
    endtask

    task automatic ahb_read(input logic [addr_width-1:0] a, output logic [31:0] data);
        @(posedge hclk);
        hsels   <= 1'b1;
        htranss <= 2'b10;
        haddrs  <= a;
        hsizes  <= 3'b010;
        hwrites <= 1'b0;
        @(posedge hclk);
        hsels   <= 1'b0;
        htranss <= 2'b00;
        @(negedge hclk);
        data = hrdatas;
        check_bit(hreadyouts, 1'b1, "hreadyout in data phase");
        check_bit(hresps, 1'b0, "hresp OKAY");
    endtask

    // Returns at the negedge before the edge that moves the byte
    task automatic send_byte(input logic [7:0] value);
        @(posedge hclk);
        dap_in_tvalid <= 1'b1;
        dap_in_tdata  <= value;
        @(negedge hclk);
        while (!dap_in_tready)
            @(negedge hclk);
    endtask

    task automatic stop_stream();
        @(posedge hclk);
        dap_in_tvalid <= 1'b0;
    endtask

    function automatic logic [7:0] byte_at(input logic [63:0] bytes, input int len,
                                           input int idx);
        return bytes[8*(len-1-idx) +: 8];
    endfunction

    task automatic set_row(input int r, input string name, input logic [63:0] in_bytes,
                           input int in_len, input logic [63:0] out_bytes, input int out_len,
                           input logic mcu, input logic [7:0] resp, input int total_us,
                           input int last_us);
        row_name[r]     = name;
        row_in[r]       = in_bytes;
        row_in_len[r]   = in_len;
        row_out[r]      = out_bytes;
        row_out_len[r]  = out_len;
        row_mcu[r]      = mcu;
        row_resp[r]     = resp;
        row_total_us[r] = total_us;
        row_last_us[r]  = last_us;
    endtask

    task automatic run_row(input int r);
        int          errs_before;
        int          last_in_cycle;
        logic [31:0] rd;
        errs_before = errors;
        out_q.delete();
        for (int i = 0; i < row_in_len[r]; i++)
            send_byte(byte_at(row_in[r], row_in_len[r], i));
        last_in_cycle = cycle + 1;
        stop_stream();
        if (row_mcu[r]) begin
            for (int w = 0; w < 10 && !intr; w++)
                @(negedge hclk);
            check_bit(intr, 1'b1, "intr raised");
            ahb_read(curcmd_addr, rd);
            check_word(rd, {24'd0, byte_at(row_in[r], row_in_len[r], 0)}, "current command");
            ahb_read(sr_addr, rd);
            check_bit(rd[31], 1'b1, "status pending bit");
            ahb_write(dr_addr, 3'b000, {24'd0, row_resp[r]});
            check_bit(out_q.size() == 0, 1'b1, "no output before release");
            ahb_write(sr_addr, 3'b010, 32'h8000_0000);  // Release bit
            @(negedge hclk);
            check_bit(intr, 1'b0, "intr cleared");
            last_in_cycle = cycle;                      // Group ends at the release
        end
        while (out_q.size() < row_out_len[r])
            @(posedge hclk);
        @(negedge hclk);
        while (!dap_in_tready)                          // Back in the command state
            @(negedge hclk);
        check_word(32'(out_q.size()), 32'(row_out_len[r]), "output byte count");
        for (int i = 0; i < row_out_len[r]; i++)
            check_byte(out_q[i], byte_at(row_out[r], row_out_len[r], i), "output byte");
        check_bit((first_out_cycle - last_in_cycle) >= row_last_us[r] * 60, 1'b1,
                  "output held until the group ends");
        report_test(row_name[r], errs_before);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] t1;
        logic [31:0] t2;
        int          start_cycle;
        int          c1;
        int          c2;
        int          errs_before;
        int          total_us;
        hclk          = 1'b0;
        hresetn       = 1'b0;
        hsels         = 1'b0;
        haddrs        = '0;
        htranss       = 2'b00;
        hsizes        = 3'b010;
        hwrites       = 1'b0;
        hreadys       = 1'b1;
        hwdatas       = 32'd0;
        dap_in_tvalid = 1'b0;
        dap_in_tdata  = 8'd0;
        cycle         = 0;
        checks        = 0;
        errors        = 0;
        tests         = 0;

        // Delay bytes are little endian
        set_row(0, "delay", 64'h09_0200, 3, 64'h0900, 2, 1'b0, 8'h00, 2, 2);
        set_row(1, "execute_commands", 64'h7F02_0901_0009_0100, 8,
                64'h7F02_0900_0900, 6, 1'b0, 8'h00, 2, 1);
        set_row(2, "mcu_command", 64'h00, 1, 64'h0004, 2, 1'b1, 8'h04, 0, 0);
        total_us = 0;
        for (int r = 0; r < num_rows; r++)
            total_us += row_total_us[r];
        timeout_limit = total_us * int'(clock_freq_mhz) + 200 * (num_rows + 3);

        repeat (3) @(posedge hclk);
        hresetn <= 1'b1;

        errs_before = errors;
        ahb_read(cr_addr, rd);
        check_word(rd, 32'd0, "control after reset");
        ahb_write(12'h002, 3'b001, 32'hABCD_1234);      // Upper halfword only
        ahb_write(cr_addr, 3'b000, 32'h5A5A_5A01);      // Lane 0 only
        ahb_read(cr_addr, rd);
        check_word(rd, 32'hABCD_0001, "merged control word");
        report_test("control_register", errs_before);

        errs_before = errors;
        start_cycle = cycle;
        ahb_write(time_addr, 3'b010, 32'd0);
        repeat (5) @(posedge hclk);
        ahb_read(time_addr, t1);
        c1 = cycle;
        ahb_read(time_addr, t2);
        c2 = cycle;
        check_bit(t1 != 32'd0, 1'b1, "timestamp nonzero");
        check_bit(t2 > t1, 1'b1, "timestamp increasing");
        check_bit(t1 < 32'(c1 - start_cycle), 1'b1, "first stamp below elapsed cycles");
        check_bit(t2 < 32'(c2 - start_cycle), 1'b1, "second stamp below elapsed cycles");
        report_test("timestamp", errs_before);

        ahb_write(cr_addr, 3'b010, 32'h8000_0001);      // Interrupt enable, enable
        for (int r = 0; r < num_rows; r++)
            run_row(r);

        errs_before = errors;
        ahb_write(cr_addr, 3'b010, 32'd0);
        out_q.delete();
        @(posedge hclk);
        dap_in_tvalid <= 1'b1;
        dap_in_tdata  <= id_delay;
        repeat (20) begin
            @(negedge hclk);
            check_bit(dap_in_tready, 1'b0, "tready low while disabled");
        end
        stop_stream();
        repeat (10) @(posedge hclk);
        check_word(32'(out_q.size()), 32'd0, "no output while disabled");
        report_test("disable", errs_before);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- source/dap_controller.sv
module dap_controller
    import dap_pkg::*;
(
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic                  hsels,
    input  logic [addr_width-1:0] haddrs,
    input  logic [1:0]            htranss,
    input  logic [2:0]            hsizes,
    input  logic                  hwrites,
    input  logic                  hreadys,
    input  logic [31:0]           hwdatas,
    output logic                  hreadyouts,
    output logic                  hresps,
    output logic [31:0]           hrdatas,
    output logic                  intr,
    input  logic                  dap_in_tvalid,
    output logic                  dap_in_tready,
    input  logic [7:0]            dap_in_tdata,
    output logic                  dap_out_tvalid,
    output logic [7:0]            dap_out_tdata
);

    logic [addr_width-1:0] addr;
    logic                  read_en;
    logic                  write_en;
    logic [3:0]            byte_strobe;
    logic                  enable;
    logic                  int_en;
    logic                  us_tick;
    logic [7:0]            processing_cmd;
    logic                  mcu_pending;
    logic                  worker_start;
    logic                  worker_in_ready;
    logic                  worker_out_valid;
    logic [7:0]            worker_out_data;
    logic                  worker_done;
    logic                  fifo_wr_en;
    logic [7:0]            fifo_wdata;
    logic                  fifo_rd_en;
    logic                  fifo_empty;

    assign hreadyouts     = 1'b1;                      // Zero wait states
    assign hresps         = 1'b0;                      // OKAY
    assign dap_out_tvalid = fifo_rd_en & ~fifo_empty;

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------
    ahb_slave_port u_ahb_port (
        .hclk, .hresetn, .hsels, .haddrs, .htranss, .hsizes, .hwrites, .hreadys,
        .addr, .read_en, .write_en, .byte_strobe
    );

    dap_reg_file u_reg_file (
        .hclk, .hresetn, .addr, .read_en, .write_en, .byte_strobe, .hwdatas,
        .in_tdata (dap_in_tdata),
        .mcu_pending, .processing_cmd, .hrdatas, .enable, .int_en, .us_tick
    );

    // ------------------------------------------------------------
    // Command path
    // ------------------------------------------------------------
    dap_sequencer u_sequencer (
        .hclk, .hresetn, .enable, .int_en, .addr, .write_en, .byte_strobe, .hwdatas,
        .dap_in_tvalid, .dap_in_tdata, .worker_in_ready, .worker_out_valid,
        .worker_out_data, .worker_done, .fifo_empty, .dap_in_tready, .worker_start,
        .fifo_wr_en, .fifo_wdata, .fifo_rd_en, .processing_cmd, .mcu_pending, .intr
    );

    dap_delay_worker u_delay_worker (
        .hclk, .hresetn, .enable, .us_tick,
        .start     (worker_start),
        .in_valid  (dap_in_tvalid),
        .in_data   (dap_in_tdata),
        .in_ready  (worker_in_ready),
        .out_valid (worker_out_valid),
        .out_data  (worker_out_data),
        .done      (worker_done)
    );

    dap_out_fifo u_out_fifo (
        .hclk, .hresetn,
        .wr_en (fifo_wr_en),
        .wdata (fifo_wdata),
        .rd_en (fifo_rd_en),
        .rdata (dap_out_tdata),
        .empty (fifo_empty),
        .full  ()
    );

endmodule

//--- source/dap_out_fifo.sv
module dap_out_fifo
    import dap_pkg::*;
(
    input  logic       hclk,
    input  logic       hresetn,
    input  logic       wr_en,
    input  logic [7:0] wdata,
    input  logic       rd_en,
    output logic [7:0] rdata,
    output logic       empty,
    output logic       full
);

    logic [7:0]            mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr_en & ~full;                      // Write when full is lost
    assign do_rd = rd_en & ~empty;
    assign empty = (count == '0);
    assign full  = (count == (fifo_ptr_w + 1)'(fifo_depth));
    assign rdata = mem[rd_ptr];                        // Head entry

    always_ff @(posedge hclk) begin
        if (do_wr)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/dap_delay_worker.sv
module dap_delay_worker
    import dap_pkg::*;
(
    input  logic       hclk,
    input  logic       hresetn,
    input  logic       enable,
    input  logic       us_tick,
    input  logic       start,
    input  logic       in_valid,
    input  logic [7:0] in_data,
    output logic       in_ready,
    output logic       out_valid,
    output logic [7:0] out_data,
    output logic       done
);

    logic [2:0]  state;
    logic [7:0]  delay_lo;
    logic [15:0] remaining;

    assign in_ready  = (state == dw_lo) || (state == dw_hi);
    assign out_valid = (state == dw_emit);
    assign out_data  = dap_ok;
    assign done      = (state == dw_done);

    always_ff @(posedge hclk) begin
        if (state == dw_lo && in_valid)
            delay_lo <= in_data;
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state     <= dw_idle;
            remaining <= 16'd0;
        end else if (!enable) begin
            state <= dw_idle;
        end else begin
            case (state)
                dw_idle: if (start) state <= dw_lo;
                dw_lo:   if (in_valid) state <= dw_hi;
                dw_hi: if (in_valid) begin
                    remaining <= {in_data, delay_lo};   // Delay in us, little endian
                    state     <= dw_count;
                end
                // One extra tick so the wait never falls short
                dw_count: if (us_tick) begin
                    if (remaining == 16'd0)
                        state <= dw_emit;
                    else
                        remaining <= remaining - 16'd1;
                end
                dw_emit: state <= dw_done;
                default: state <= dw_idle;
            endcase
        end
    end

endmodule

//--- source/dap_sequencer.sv
module dap_sequencer
    import dap_pkg::*;
(
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic                  enable,
    input  logic                  int_en,
    input  logic [addr_width-1:0] addr,
    input  logic                  write_en,
    input  logic [3:0]            byte_strobe,
    input  dap_wdata_u            hwdatas,
    input  logic                  dap_in_tvalid,
    input  logic [7:0]            dap_in_tdata,
    input  logic                  worker_in_ready,
    input  logic                  worker_out_valid,
    input  logic [7:0]            worker_out_data,
    input  logic                  worker_done,
    input  logic                  fifo_empty,
    output logic                  dap_in_tready,
    output logic                  worker_start,
    output logic                  fifo_wr_en,
    output logic [7:0]            fifo_wdata,
    output logic                  fifo_rd_en,
    output logic [7:0]            processing_cmd,
    output logic                  mcu_pending,
    output logic                  intr
);

    logic [1:0] state;
    logic [7:0] num_cmd;
    logic [7:0] decode_cmd;
    cmd_class_t cmd_class;
    logic       stream_phase;
    logic       in_fire;
    logic       dr_wr;
    logic       release_wr;

    // Live byte in the command state, held command otherwise
    assign decode_cmd = (state == seq_cmd) ? dap_in_tdata : processing_cmd;

    always_comb begin
        case (decode_cmd)
            id_delay:                               cmd_class = class_delay;
            id_queue_commands, id_execute_commands: cmd_class = class_exec;
            default:                                cmd_class = class_mcu;
        endcase
    end

    assign stream_phase  = (state == seq_cmd) || (state == seq_count);
    assign dap_in_tready = enable & (stream_phase |
                           (state == seq_wait && cmd_class == class_delay && worker_in_ready));
    assign in_fire       = dap_in_tvalid & dap_in_tready;

    assign dr_wr      = write_en && byte_strobe[0] &&
                        (addr[addr_width-1:2] == dr_addr[addr_width-1:2]);
    assign release_wr = write_en && byte_strobe[3] && hwdatas.status.release_bit &&
                        (addr[addr_width-1:2] == sr_addr[addr_width-1:2]);
    assign intr       = int_en & mcu_pending;

    // ------------------------------------------------------------
    // Command FSM
    // ------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state          <= seq_cmd;
            num_cmd        <= 8'd0;
            processing_cmd <= 8'd0;
            mcu_pending    <= 1'b0;
            fifo_rd_en     <= 1'b0;
            worker_start   <= 1'b0;
        end else if (!enable) begin
            state          <= seq_cmd;
            num_cmd        <= 8'd0;
            processing_cmd <= 8'd0;
            mcu_pending    <= 1'b0;
            fifo_rd_en     <= 1'b0;
            worker_start   <= 1'b0;
        end else begin
            worker_start <= 1'b0;                       // Single-cycle pulse
            case (state)
                seq_cmd: if (in_fire) begin
                    processing_cmd <= dap_in_tdata;
                    case (cmd_class)
                        class_exec:  state <= seq_count;
                        class_delay: begin
                            state        <= seq_wait;
                            worker_start <= 1'b1;
                        end
                        default: begin                  // Hand off to the MCU
                            state       <= seq_wait;
                            mcu_pending <= 1'b1;
                        end
                    endcase
                end
                seq_count: if (in_fire) begin
                    num_cmd <= dap_in_tdata;
                    state   <= seq_cmd;
                end
                seq_wait: begin
                    if (cmd_class == class_mcu) begin
                        if (release_wr) begin
                            mcu_pending <= 1'b0;
                            state       <= seq_next;
                        end
                    end else if (worker_done) begin
                        state <= seq_next;
                    end
                end
                default: begin
                    if (num_cmd > 8'd1) begin           // More commands in the group
                        num_cmd <= num_cmd - 8'd1;
                        state   <= seq_cmd;
                    end else begin
                        num_cmd <= 8'd0;
                        if (fifo_empty) begin
                            fifo_rd_en <= 1'b0;
                            state      <= seq_cmd;
                        end else begin
                            fifo_rd_en <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Output FIFO write source, MCU first
    always_comb begin
        fifo_wr_en = 1'b0;
        fifo_wdata = 8'd0;
        if (dr_wr) begin
            fifo_wr_en = 1'b1;
            fifo_wdata = hwdatas[7:0];
        end else if (stream_phase) begin
            fifo_wr_en = in_fire;                       // Echo command and count
            fifo_wdata = dap_in_tdata;
        end else if (state == seq_wait && cmd_class == class_delay) begin
            fifo_wr_en = worker_out_valid;
            fifo_wdata = worker_out_data;
        end
    end

endmodule

//--- source/dap_reg_file.sv
module dap_reg_file
    import dap_pkg::*;
(
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic [addr_width-1:0] addr,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [3:0]            byte_strobe,
    input  dap_wdata_u            hwdatas,
    input  logic [7:0]            in_tdata,
    input  logic                  mcu_pending,
    input  logic [7:0]            processing_cmd,
    output logic [31:0]           hrdatas,
    output logic                  enable,
    output logic                  int_en,
    output logic                  us_tick
);

    dap_wdata_u  ctrl_q;
    logic [31:0] timestamp;
    logic [5:0]  us_div;
    logic        ctrl_wr;
    logic        time_wr;

    assign ctrl_wr = write_en && (addr[addr_width-1:2] == cr_addr[addr_width-1:2]);
    assign time_wr = write_en && (addr[addr_width-1:2] == time_addr[addr_width-1:2]);

    assign enable  = ctrl_q.ctrl.enable;
    assign int_en  = ctrl_q.ctrl.int_en;
    assign us_tick = (us_div == clock_freq_mhz - 6'd1);

    // ------------------------------------------------------------
    // Control register, written per byte lane
    // ------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_strobe[i])
                    ctrl_q[8*i +: 8] <= hwdatas[8*i +: 8];
            end
        end
    end

    // Cycle timestamp and us divider, both restart on a time write
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            timestamp <= 32'd0;
            us_div    <= 6'd0;
        end else if (time_wr) begin
            timestamp <= 32'd0;
            us_div    <= 6'd0;
        end else begin
            timestamp <= timestamp + 32'd1;
            us_div    <= us_tick ? 6'd0 : us_div + 6'd1;
        end
    end

    // ------------------------------------------------------------
    // Read data, valid in the data phase
    // ------------------------------------------------------------
    always_comb begin
        hrdatas = 32'd0;
        if (read_en) begin
            case (addr[addr_width-1:2])
                cr_addr[addr_width-1:2]:     hrdatas = ctrl_q;
                time_addr[addr_width-1:2]:   hrdatas = timestamp;
                sr_addr[addr_width-1:2]:     hrdatas = {mcu_pending, 31'd0};
                dr_addr[addr_width-1:2]:     hrdatas = {4{in_tdata}};  // Peek at input
                curcmd_addr[addr_width-1:2]: hrdatas = {24'd0, processing_cmd};
                default:                     hrdatas = 32'd0;
            endcase
        end
    end

endmodule

//--- source/ahb_slave_port.sv
module ahb_slave_port
    import dap_pkg::*;
(
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic                  hsels,
    input  logic [addr_width-1:0] haddrs,
    input  logic [1:0]            htranss,
    input  logic [2:0]            hsizes,
    input  logic                  hwrites,
    input  logic                  hreadys,
    output logic [addr_width-1:0] addr,
    output logic                  read_en,
    output logic                  write_en,
    output logic [3:0]            byte_strobe
);

    logic       trans_req;
    logic       rd_req;
    logic       wr_req;
    logic       update;
    logic [3:0] strobe_nxt;

    assign trans_req = hsels & hreadys & htranss[1];  // NONSEQ or SEQ only
    assign rd_req    = trans_req & ~hwrites;
    assign wr_req    = trans_req & hwrites;

    // New request, or close of the current data phase
    assign update = trans_req | ((read_en | write_en) & hreadys);

    // Lane decode from size and low address bits
    always_comb begin
        case (hsizes)
            3'b000:  strobe_nxt = 4'b0001 << haddrs[1:0];
            3'b001:  strobe_nxt = haddrs[1] ? 4'b1100 : 4'b0011;
            default: strobe_nxt = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr        <= '0;
            read_en     <= 1'b0;
            write_en    <= 1'b0;
            byte_strobe <= 4'b0000;
        end else begin
            if (trans_req)
                addr <= haddrs;
            if (update) begin
                read_en     <= rd_req;
                write_en    <= wr_req;
                byte_strobe <= strobe_nxt;
            end
        end
    end

endmodule

//--- source/dap_pkg.sv
package dap_pkg;

    // ------------------------------------------------------------
    // Bus and timing constants
    // ------------------------------------------------------------
    localparam int         addr_width     = 12;
    localparam logic [5:0] clock_freq_mhz = 6'd60;      // hclk cycles per us
    localparam int         fifo_depth     = 16;
    localparam int         fifo_ptr_w     = $clog2(fifo_depth);

    // Register word offsets, decoded on bits 11:2
    localparam logic [addr_width-1:0] cr_addr     = 12'h000;
    localparam logic [addr_width-1:0] time_addr   = 12'h004;
    localparam logic [addr_width-1:0] sr_addr     = 12'h008;
    localparam logic [addr_width-1:0] dr_addr     = 12'h00C;
    localparam logic [addr_width-1:0] curcmd_addr = 12'h010;

    // CMSIS-DAP command IDs
    localparam logic [7:0] id_delay            = 8'h09;
    localparam logic [7:0] id_queue_commands   = 8'h7E;
    localparam logic [7:0] id_execute_commands = 8'h7F;
    localparam logic [7:0] dap_ok              = 8'h00;  // Response status byte

    // Sequencer states
    localparam logic [1:0] seq_cmd   = 2'd0;
    localparam logic [1:0] seq_count = 2'd1;
    localparam logic [1:0] seq_wait  = 2'd2;
    localparam logic [1:0] seq_next  = 2'd3;

    // Delay worker states
    localparam logic [2:0] dw_idle  = 3'd0;
    localparam logic [2:0] dw_lo    = 3'd1;
    localparam logic [2:0] dw_hi    = 3'd2;
    localparam logic [2:0] dw_count = 3'd3;
    localparam logic [2:0] dw_emit  = 3'd4;
    localparam logic [2:0] dw_done  = 3'd5;

    typedef enum logic [1:0] {
        class_delay,
        class_exec,
        class_mcu
    } cmd_class_t;

    // One AHB write word, seen as control or status layout
    typedef union packed {
        struct packed {
            logic        int_en;
            logic [29:0] reserved;
            logic        enable;
        } ctrl;
        struct packed {
            logic        release_bit;
            logic [30:0] reserved;
        } status;
    } dap_wdata_u;

endpackage
